//--- hdl/alu.sv
module alu (
    input  logic                              clk,
    input  logic [riscv_isa_pkg::XLEN-1:0]    operand_a,
    input  logic [riscv_isa_pkg::XLEN-1:0]    operand_b,
    input  core_ctrl_pkg::alu_op_t            alu_operation,
    output logic [riscv_isa_pkg::XLEN-1:0]    result
);
    import core_ctrl_pkg::*;

    logic [4:0] shamt;

    assign shamt = operand_b[4:0];  // Low 5 bits only

    always_comb begin
        case (alu_operation)
            ALU_ADD:    result = operand_a + operand_b;
            ALU_SUB:    result = operand_a - operand_b;
            ALU_SLL:    result = operand_a << shamt;
            ALU_SLT:    result = {31'b0, $signed(operand_a) < $signed(operand_b)};
            ALU_SLTU:   result = {31'b0, operand_a < operand_b};
            ALU_XOR:    result = operand_a ^ operand_b;
            ALU_SRL:    result = operand_a >> shamt;
            ALU_SRA:    result = $unsigned($signed(operand_a) >>> shamt);
            ALU_OR:     result = operand_a | operand_b;
            ALU_AND:    result = operand_a & operand_b;
            ALU_PASS_B: result = operand_b;             // lui
            default:    result = '0;
        endcase
    end

    // ####################
    // Checks
    // ####################
    operation_defined: assert property (
        @(posedge clk)
        alu_operation inside {ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
                              ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B}
    ) else $error("Undefined ALU operation %0d", alu_operation);

endmodule

//--- hdl/alu_controller.sv
module alu_controller (
    input  core_ctrl_pkg::alu_option_t             alu_option,
    input  logic [riscv_isa_pkg::FUNCT3_W-1:0]     funct3,
    input  logic                                   funct7_bit5,
    output core_ctrl_pkg::alu_op_t                 alu_operation
);
    import riscv_isa_pkg::*;
    import core_ctrl_pkg::*;

    always_comb begin
        alu_operation = ALU_ADD;  // Loads, stores, auipc
        case (alu_option)
            CLS_LUI: alu_operation = ALU_PASS_B;
            CLS_IMM, CLS_REG: begin
                case (funct3)
                    F3_ADD: begin
                        // Only the register form has sub
                        if (alu_option == CLS_REG && funct7_bit5) begin
                            alu_operation = ALU_SUB;
                        end else begin
                            alu_operation = ALU_ADD;
                        end
                    end
                    F3_SLL:  alu_operation = ALU_SLL;
                    F3_SLT:  alu_operation = ALU_SLT;
                    F3_SLTU: alu_operation = ALU_SLTU;
                    F3_XOR:  alu_operation = ALU_XOR;
                    F3_SR:   alu_operation = funct7_bit5 ? ALU_SRA : ALU_SRL;
                    F3_OR:   alu_operation = ALU_OR;
                    default: alu_operation = ALU_AND;
                endcase
            end
            CLS_BRANCH: begin
                case (funct3)
                    F3_BEQ, F3_BNE: alu_operation = ALU_SUB;  // Zero test
                    F3_BLT, F3_BGE: alu_operation = ALU_SLT;
                    default:        alu_operation = ALU_SLTU;
                endcase
            end
            default: begin
            end
        endcase
    end

endmodule

//--- hdl/core_ctrl_pkg.sv
package core_ctrl_pkg;

    // Class code built from opcode bits 6:4 and 2
    typedef enum logic [3:0] {
        CLS_LOAD   = 4'b0000,
        CLS_IMM    = 4'b0010,
        CLS_AUIPC  = 4'b0011,
        CLS_STORE  = 4'b0100,
        CLS_REG    = 4'b0110,
        CLS_LUI    = 4'b0111,
        CLS_BRANCH = 4'b1100
    } alu_option_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_t;

    typedef enum logic [1:0] {
        SEL_RS1  = 2'b00,
        SEL_PC   = 2'b01,  // auipc
        SEL_ZERO = 2'b10   // lui
    } operand_a_sel_t;

    typedef enum logic [1:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U
    } imm_fmt_t;

endpackage

//--- hdl/immediate_generator.sv
module immediate_generator (
    input  logic [riscv_isa_pkg::XLEN-1:0] instruction,
    output logic [riscv_isa_pkg::XLEN-1:0] immediate
);
    import riscv_isa_pkg::*;
    import core_ctrl_pkg::*;

    imm_fmt_t imm_format;

    always_comb begin
        case (opcode_t'(instruction[6:0]))
            OP_STORE:         imm_format = IMM_S;
            OP_BRANCH:        imm_format = IMM_B;
            OP_LUI, OP_AUIPC: imm_format = IMM_U;
            default:          imm_format = IMM_I;  // Loads and ALU immediates
        endcase
    end

    always_comb begin
        case (imm_format)
            IMM_S: immediate = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
            IMM_B: begin
                immediate = {{19{instruction[31]}}, instruction[31], instruction[7],
                             instruction[30:25], instruction[11:8], 1'b0};
            end
            IMM_U:   immediate = {instruction[31:12], 12'b0};
            default: immediate = {{20{instruction[31]}}, instruction[31:20]};
        endcase
    end

endmodule

//--- hdl/main_controller.sv
module main_controller (
    input  logic                          reset,
    input  riscv_isa_pkg::opcode_t        opcode,
    output logic                          branch,
    output logic                          memory_read,
    output logic                          memory_to_register,
    output core_ctrl_pkg::alu_option_t    alu_option,
    output logic                          memory_write,
    output logic                          alu_source,
    output logic                          register_write,
    output core_ctrl_pkg::operand_a_sel_t AuipcLui
);
    import core_ctrl_pkg::*;

    assign alu_option = alu_option_t'({opcode[6:4], opcode[2]});

    always_comb begin
        alu_source         = 1'b0;  // All low for unknown opcodes
        memory_to_register = 1'b0;
        memory_read        = 1'b0;
        memory_write       = 1'b0;
        register_write     = 1'b0;
        branch             = 1'b0;
        AuipcLui           = SEL_RS1;

        case (alu_option)
            CLS_LOAD: begin
                alu_source         = 1'b1;
                memory_to_register = 1'b1;  // Write back the loaded word
                memory_read        = 1'b1;
                register_write     = 1'b1;
            end
            CLS_IMM: begin
                alu_source     = 1'b1;
                register_write = 1'b1;
            end
            CLS_AUIPC: begin
                alu_source     = 1'b1;
                register_write = 1'b1;
                AuipcLui       = SEL_PC;    // PC plus upper immediate
            end
            CLS_STORE: begin
                alu_source   = 1'b1;        // Address is rs1 plus offset
                memory_write = 1'b1;
            end
            CLS_REG: begin
                register_write = 1'b1;
            end
            CLS_LUI: begin
                alu_source     = 1'b1;
                register_write = 1'b1;
                AuipcLui       = SEL_ZERO;
            end
            CLS_BRANCH: begin
                branch = 1'b1;              // Compare rs1 with rs2
            end
            default: begin
            end
        endcase

        // Nothing retires while reset is held
        if (reset) begin
            register_write = 1'b0;
            memory_write   = 1'b0;
        end
    end

endmodule

//--- hdl/program_counter.sv
module program_counter (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                branch,
    input  logic [riscv_isa_pkg::FUNCT3_W-1:0]  funct3,
    input  logic [riscv_isa_pkg::XLEN-1:0]      alu_result,
    input  logic [riscv_isa_pkg::XLEN-1:0]      immediate,
    output logic [riscv_isa_pkg::XLEN-1:0]      pc
);
    import riscv_isa_pkg::*;

    logic            taken;
    logic [XLEN-1:0] pc_next;

    always_comb begin
        case (funct3)
            F3_BEQ:           taken = (alu_result == '0);
            F3_BNE:           taken = (alu_result != '0);
            F3_BLT, F3_BLTU:  taken = alu_result[0];   // Set-less-than result
            F3_BGE, F3_BGEU:  taken = !alu_result[0];
            default:          taken = 1'b0;
        endcase
    end

    assign pc_next = (branch && taken) ? pc + immediate : pc + 32'd4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else $error("PC not word aligned: %h", pc);

endmodule

//--- hdl/register_bank.sv
module register_bank (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic [riscv_isa_pkg::REG_ADDR_W-1:0]  read_register_1,
    input  logic [riscv_isa_pkg::REG_ADDR_W-1:0]  read_register_2,
    input  logic [riscv_isa_pkg::REG_ADDR_W-1:0]  write_register,
    input  logic [riscv_isa_pkg::XLEN-1:0]        write_data,
    input  logic                                  register_write,
    output logic [riscv_isa_pkg::XLEN-1:0]        read_data_1,
    output logic [riscv_isa_pkg::XLEN-1:0]        read_data_2
);
    import riscv_isa_pkg::*;

    logic [XLEN-1:0] registers [NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                registers[i] <= '0;
            end
        end else if (register_write && write_register != '0) begin  // x0 stays zero
            registers[write_register] <= write_data;
        end
    end

    // Asynchronous read ports
    assign read_data_1 = (read_register_1 == '0) ? '0 : registers[read_register_1];
    assign read_data_2 = (read_register_2 == '0) ? '0 : registers[read_register_2];

endmodule

//--- hdl/riscv_core.sv
module riscv_core (
    input  logic                                  clk,
    input  logic                                  reset,
    // ####################
    // Fetch port
    // ####################
    output logic [riscv_isa_pkg::XLEN-1:0]        instruction_address,
    input  logic [riscv_isa_pkg::XLEN-1:0]        instruction,
    // ####################
    // Data port
    // ####################
    output logic [riscv_isa_pkg::XLEN-1:0]        data_address,
    output logic [riscv_isa_pkg::XLEN-1:0]        data_write_data,
    output logic                                  memory_read,
    output logic                                  memory_write,
    input  logic [riscv_isa_pkg::XLEN-1:0]        data_read_data,
    // ####################
    // Write-back port
    // ####################
    output logic                                  register_write,
    output logic [riscv_isa_pkg::REG_ADDR_W-1:0]  write_register,
    output logic [riscv_isa_pkg::XLEN-1:0]        write_back_data
);
    import riscv_isa_pkg::*;
    import core_ctrl_pkg::*;

    logic            alu_source;
    logic            memory_to_register;
    logic            branch;
    alu_option_t     alu_option;
    operand_a_sel_t  operand_a_select;
    alu_op_t         alu_operation;
    logic [XLEN-1:0] immediate;
    logic [XLEN-1:0] read_data_1;
    logic [XLEN-1:0] read_data_2;
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
    logic [XLEN-1:0] alu_result;

    assign write_register  = instruction[11:7];  // rd
    assign data_address    = alu_result;
    assign data_write_data = read_data_2;

    main_controller main_controller0 (
        .reset(reset), .opcode(opcode_t'(instruction[6:0])), .branch(branch),
        .memory_read(memory_read), .memory_to_register(memory_to_register),
        .alu_option(alu_option), .memory_write(memory_write), .alu_source(alu_source),
        .register_write(register_write), .AuipcLui(operand_a_select)
    );

    alu_controller alu_controller0 (
        .alu_option(alu_option), .funct3(instruction[14:12]),
        .funct7_bit5(instruction[30]), .alu_operation(alu_operation)
    );

    register_bank register_bank0 (
        .clk(clk), .reset(reset), .read_register_1(instruction[19:15]),
        .read_register_2(instruction[24:20]), .write_register(write_register),
        .write_data(write_back_data), .register_write(register_write),
        .read_data_1(read_data_1), .read_data_2(read_data_2)
    );

    immediate_generator immediate_generator0 (.instruction(instruction), .immediate(immediate));

    // Source selects
    assign operand_a = (operand_a_select == SEL_PC)   ? instruction_address :
                       (operand_a_select == SEL_ZERO) ? '0 : read_data_1;
    assign operand_b = alu_source ? immediate : read_data_2;
    assign write_back_data = memory_to_register ? data_read_data : alu_result;

    alu alu0 (
        .clk(clk), .operand_a(operand_a), .operand_b(operand_b),
        .alu_operation(alu_operation), .result(alu_result)
    );

    program_counter program_counter0 (
        .clk(clk), .reset(reset), .branch(branch), .funct3(instruction[14:12]),
        .alu_result(alu_result), .immediate(immediate), .pc(instruction_address)
    );

endmodule

//--- hdl/riscv_isa_pkg.sv
package riscv_isa_pkg;

    localparam int XLEN       = 32;               // Data and instruction width
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 1 << REG_ADDR_W;  // x0 to x31
    localparam int FUNCT3_W   = 3;

    // ####################
    // Major opcodes
    // ####################
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_IMM    = 7'b0010011,
        OP_AUIPC  = 7'b0010111,
        OP_STORE  = 7'b0100011,
        OP_REG    = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_BRANCH = 7'b1100011
    } opcode_t;

    // ####################
    // Branch funct3
    // ####################
    localparam logic [FUNCT3_W-1:0] F3_BEQ  = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_BNE  = 3'b001;
    localparam logic [FUNCT3_W-1:0] F3_BLT  = 3'b100;
    localparam logic [FUNCT3_W-1:0] F3_BGE  = 3'b101;
    localparam logic [FUNCT3_W-1:0] F3_BLTU = 3'b110;
    localparam logic [FUNCT3_W-1:0] F3_BGEU = 3'b111;

    // ####################
    // ALU funct3
    // ####################
    localparam logic [FUNCT3_W-1:0] F3_ADD  = 3'b000;  // Also sub
    localparam logic [FUNCT3_W-1:0] F3_SLL  = 3'b001;
    localparam logic [FUNCT3_W-1:0] F3_SLT  = 3'b010;
    localparam logic [FUNCT3_W-1:0] F3_SLTU = 3'b011;
    localparam logic [FUNCT3_W-1:0] F3_XOR  = 3'b100;
    localparam logic [FUNCT3_W-1:0] F3_SR   = 3'b101;  // srl and sra
    localparam logic [FUNCT3_W-1:0] F3_OR   = 3'b110;
    localparam logic [FUNCT3_W-1:0] F3_AND  = 3'b111;

endpackage

//--- run_sim.sh
#!/bin/sh
# Compile and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module tb_riscv_core -o sim_tb
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Done: no errors"; then
    exit 0
fi
exit 1

//--- src.f
hdl/riscv_isa_pkg.sv
hdl/core_ctrl_pkg.sv
hdl/main_controller.sv
hdl/alu_controller.sv
hdl/alu.sv
hdl/register_bank.sv
hdl/immediate_generator.sv
hdl/program_counter.sv
hdl/riscv_core.sv
verification/core_checker.sv
verification/tb_riscv_core.sv

//--- verification/core_checker.sv
module core_checker (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic [riscv_isa_pkg::XLEN-1:0]        instruction_address,
    input  logic [riscv_isa_pkg::XLEN-1:0]        instruction,
    input  logic [riscv_isa_pkg::XLEN-1:0]        data_address,
    input  logic [riscv_isa_pkg::XLEN-1:0]        data_write_data,
    input  logic                                  memory_read,
    input  logic                                  memory_write,
    input  logic                                  register_write,
    input  logic [riscv_isa_pkg::REG_ADDR_W-1:0]  write_register,
    input  logic [riscv_isa_pkg::XLEN-1:0]        write_back_data,
    output int                                    error_count,
    output int                                    check_count
);
    timeunit 1ns;
    timeprecision 100ps;
    import riscv_isa_pkg::*;

    logic [XLEN-1:0] reg_model [NUM_REGS];
    logic [XLEN-1:0] mem_model [256];
    logic            mem_valid [256];     // Word written by the program
    logic [XLEN-1:0] pending_pc;
    int              test_errors = 0;
    int              test_checks = 0;

    initial begin
        error_count = 0;
        check_count = 0;
    end

    // ####################
    // Reference model
    // ####################
    function automatic logic [XLEN-1:0] alu_ref(input logic [2:0] f3, input logic alt,
                                                 input logic [XLEN-1:0] x, input logic [XLEN-1:0] y);
        case (f3)
            F3_ADD:  return alt ? x - y : x + y;
            F3_SLL:  return x << y[4:0];
            F3_SLT:  return {31'b0, $signed(x) < $signed(y)};
            F3_SLTU: return {31'b0, x < y};
            F3_XOR:  return x ^ y;
            F3_SR:   return alt ? $unsigned($signed(x) >>> y[4:0]) : x >> y[4:0];
            F3_OR:   return x | y;
            default: return x & y;
        endcase
    endfunction

    function automatic void reference_step(
        input  logic [XLEN-1:0] inst,
        input  logic [XLEN-1:0] pc,
        output logic            we,
        output logic [4:0]      rd,
        output logic [XLEN-1:0] wdata,
        output logic            wdata_known,
        output logic            mr,
        output logic            mw,
        output logic [XLEN-1:0] addr,
        output logic [XLEN-1:0] sdata,
        output logic [XLEN-1:0] next_pc
    );
        logic [2:0]      f3;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] imm_i;
        logic [XLEN-1:0] imm_s;
        logic [XLEN-1:0] imm_b;
        logic [XLEN-1:0] imm_u;
        logic            cond;
        f3    = inst[14:12];
        rd    = inst[11:7];
        a     = reg_model[inst[19:15]];
        b     = reg_model[inst[24:20]];
        imm_i = {{20{inst[31]}}, inst[31:20]};
        imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_u = {inst[31:12], 12'b0};
        we = 1'b0;
        wdata = '0;
        wdata_known = 1'b1;
        mr = 1'b0;
        mw = 1'b0;
        addr = '0;
        sdata = '0;
        next_pc = pc + 4;
        cond = 1'b0;
        case (inst[6:0])
            OP_IMM: begin
                we = 1'b1;
                wdata = alu_ref(f3, f3 == F3_SR && inst[30], a, imm_i);  // Only srai uses bit 30
            end
            OP_REG: begin
                we = 1'b1;
                wdata = alu_ref(f3, inst[30], a, b);
            end
            OP_LUI: begin
                we = 1'b1;
                wdata = imm_u;
            end
            OP_AUIPC: begin
                we = 1'b1;
                wdata = pc + imm_u;
            end
            OP_LOAD: begin
                we = 1'b1;
                mr = 1'b1;
                addr = a + imm_i;
                wdata = mem_model[addr[9:2]];
                wdata_known = mem_valid[addr[9:2]];
            end
            OP_STORE: begin
                mw = 1'b1;
                addr = a + imm_s;
                sdata = b;
            end
            OP_BRANCH: begin
                case (f3)
                    F3_BEQ:  cond = (a == b);
                    F3_BNE:  cond = (a != b);
                    F3_BLT:  cond = ($signed(a) < $signed(b));
                    F3_BGE:  cond = ($signed(a) >= $signed(b));
                    F3_BLTU: cond = (a < b);
                    F3_BGEU: cond = (a >= b);
                    default: cond = 1'b0;
                endcase
                if (cond) next_pc = pc + imm_b;
            end
            default: begin
            end
        endcase
    endfunction

    task automatic check(input logic ok, input string what);
        check_count++;
        test_checks++;
        if (!ok) begin
            error_count++;
            test_errors++;
            $display("mismatch at %0t: %s", $time, what);
        end
    endtask

    task automatic report_test(input string name);
        $display("test %-12s %0d checks, %0d errors, %s", name, test_checks, test_errors,
                 (test_errors == 0) ? "pass" : "FAIL");
        test_checks = 0;
        test_errors = 0;
    endtask

    // ####################
    // Compare
    // ####################
    always @(posedge clk) begin : compare
        logic            we;
        logic [4:0]      rd;
        logic [XLEN-1:0] wdata;
        logic            known;
        logic            mr;
        logic            mw;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] sdata;
        logic [XLEN-1:0] next_pc;
        if (reset) begin
            check(!register_write, "register_write high during reset");
            check(!memory_write, "memory_write high during reset");
            for (int i = 0; i < NUM_REGS; i++) reg_model[i] = '0;
            for (int i = 0; i < 256; i++) mem_valid[i] = 1'b0;
            pending_pc = '0;                         // First fetch after reset
        end else begin
            check(instruction_address == pending_pc,
                  $sformatf("pc %h, expected %h", instruction_address, pending_pc));
            reference_step(instruction, instruction_address, we, rd, wdata, known,
                           mr, mw, addr, sdata, next_pc);
            check(register_write == we, $sformatf("register_write %b for %h", register_write,
                                                  instruction));
            if (we) begin
                check(write_register == rd, $sformatf("rd %0d, expected %0d", write_register, rd));
                if (known) begin
                    check(write_back_data == wdata, $sformatf("write-back %h, expected %h for %h",
                                                              write_back_data, wdata, instruction));
                end
            end
            check(memory_read == mr, $sformatf("memory_read %b for %h", memory_read, instruction));
            check(memory_write == mw, $sformatf("memory_write %b for %h", memory_write,
                                                instruction));
            if (mr || mw) begin
                check(data_address == addr, $sformatf("address %h, expected %h", data_address, addr));
            end
            if (mw) begin
                check(data_write_data == sdata, $sformatf("store data %h, expected %h",
                                                          data_write_data, sdata));
                mem_model[addr[9:2]] = sdata;
                mem_valid[addr[9:2]] = 1'b1;
            end
            if (we && rd != 0) reg_model[rd] = wdata;  // x0 never changes
            pending_pc = next_pc;
        end
    end

endmodule

//--- verification/tb_riscv_core.sv
module tb_riscv_core;
    timeunit 1ns;
    timeprecision 100ps;
    import riscv_isa_pkg::*;

    localparam logic [31:0] SEED = 32'hfe85_9f26;

    logic            clk;
    logic            reset;
    logic [XLEN-1:0] instruction_address;
    logic [XLEN-1:0] instruction;
    logic [XLEN-1:0] data_address;
    logic [XLEN-1:0] data_write_data;
    logic            memory_read;
    logic            memory_write;
    logic [XLEN-1:0] data_read_data;
    logic            register_write;
    logic [4:0]      write_register;
    logic [XLEN-1:0] write_back_data;
    int              error_count;
    int              check_count;

    logic [XLEN-1:0] imem [256];
    logic [XLEN-1:0] dmem [256];
    int              n = 0;               // Program length in words
    logic            program_ready = 1'b0;
    string           section_names [$];
    int              section_ends [$];

    riscv_core dut0 (
        .clk(clk), .reset(reset), .instruction_address(instruction_address),
        .instruction(instruction), .data_address(data_address),
        .data_write_data(data_write_data), .memory_read(memory_read),
        .memory_write(memory_write), .data_read_data(data_read_data),
        .register_write(register_write), .write_register(write_register),
        .write_back_data(write_back_data)
    );

    core_checker checker0 (
        .clk(clk), .reset(reset), .instruction_address(instruction_address),
        .instruction(instruction), .data_address(data_address),
        .data_write_data(data_write_data), .memory_read(memory_read),
        .memory_write(memory_write),
        .register_write(register_write), .write_register(write_register),
        .write_back_data(write_back_data), .error_count(error_count),
        .check_count(check_count)
    );

    // ####################
    // Clock and memories
    // ####################
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    assign instruction    = imem[instruction_address[9:2]];
    assign data_read_data = dmem[data_address[9:2]];

    always @(posedge clk) begin
        if (memory_write) dmem[data_address[9:2]] <= data_write_data;
    end

    // ####################
    // Program building
    // ####################
    task automatic emit(input logic [31:0] word);
        imem[n] = word;
        n++;
    endtask

    function automatic logic [31:0] enc_r(input logic alt, input int rs2, input int rs1,
                                          input logic [2:0] f3, input int rd);
        return {1'b0, alt, 5'b0, 5'(rs2), 5'(rs1), f3, 5'(rd), OP_REG};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input int rs1,
                                          input logic [2:0] f3, input int rd, input opcode_t op);
        return {imm, 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input int rs2, input int rs1);
        return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input int rs2, input int rs1,
                                          input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    task automatic load_constant(input int rd, input logic [31:0] value);
        logic [31:0] upper;
        upper = value + 32'h800;                // Undo the sign of the low part
        emit({upper[31:12], 5'(rd), OP_LUI});
        emit(enc_i(value[11:0], rd, F3_ADD, rd, OP_IMM));
    endtask

    task automatic end_section(input string name);
        section_names.push_back(name);
        section_ends.push_back(n * 4);
    endtask

    task automatic build_program();
        logic [2:0]  f3;
        logic [11:0] imm;
        logic        alt;
        logic [31:0] a;
        logic [31:0] b;
        int          k;
        logic [2:0]  branch_f3 [6] = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
        for (int r = 1; r <= 8; r++) load_constant(r, $urandom);
        repeat (24) begin
            f3 = 3'($urandom);
            imm = 12'($urandom);
            if (f3 == F3_SLL) imm[11:5] = 7'b0;  // Shift amount only
            if (f3 == F3_SR) imm[11:5] = {1'b0, 1'($urandom), 5'b0};
            emit(enc_i(imm, 1 + $urandom % 15, f3, 1 + $urandom % 15, OP_IMM));
        end
        end_section("alu_imm");
        repeat (24) begin
            f3 = 3'($urandom);
            alt = (f3 == F3_ADD || f3 == F3_SR) ? 1'($urandom) : 1'b0;
            emit(enc_r(alt, 1 + $urandom % 15, 1 + $urandom % 15, f3, 1 + $urandom % 15));
        end
        end_section("alu_reg");
        repeat (12) begin
            emit({20'($urandom), 5'(1 + $urandom % 15), ($urandom % 2) ? OP_LUI : OP_AUIPC});
        end
        end_section("upper");
        load_constant(20, 32'h100);             // Base in the middle of data memory
        for (int i = 0; i < 8; i++) begin
            k = $urandom % 32;
            load_constant(21, $urandom);
            emit(enc_s(12'(4 * k - 64), 21, 20));
            emit(enc_i(12'(4 * k - 64), 20, 3'b010, 22 + i % 4, OP_LOAD));
        end
        end_section("load_store");
        foreach (branch_f3[j]) begin
            repeat (3) begin
                a = $urandom;
                b = ($urandom % 2) ? a : $urandom;
                load_constant(5, a);
                load_constant(6, b);
                emit(enc_b(13'(4 * (2 + $urandom % 2)), 6, 5, branch_f3[j]));  // Skips one or two
                emit(enc_i(12'd1, 0, F3_ADD, 7, OP_IMM));
                emit(enc_i(12'd2, 0, F3_ADD, 8, OP_IMM));
            end
        end
        end_section("branch");
        emit(enc_i(12'($urandom), 0, F3_ADD, 0, OP_IMM));
        emit(enc_r(1'b0, 0, 0, F3_ADD, 9));
        emit({20'($urandom), 5'd0, OP_LUI});
        emit(enc_r(1'b0, 0, 0, F3_ADD, 10));
        end_section("x0_write");
        emit(enc_b(13'd0, 0, 0, F3_BEQ));       // Park on a self loop
    endtask

    // ####################
    // Main sequence
    // ####################
    initial begin
        reset = 1'b1;
        void'($urandom(SEED));
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
            dmem[i] = 32'hc0de_0000 ^ (i * 32'h0001_0203);
        end
        imem[0] = enc_s(12'd0, 0, 0);           // A store at the reset PC first
        repeat (2) @(posedge clk);
        @(negedge clk);
        build_program();                        // Then the program's first word
        program_ready = 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        foreach (section_ends[s]) begin
            do @(negedge clk); while (instruction_address != section_ends[s]);
            @(negedge clk);                     // Let the last next-PC check land
            checker0.report_test(section_names[s]);
        end
        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        wait (program_ready);
        #(n * 4 * 4 + 200 + 5 * 4);
        $display("timeout: the program did not reach its end in time");
        $display("Done: errors found");
        $finish;
    end

endmodule
